/* bench/dualDecodeStage_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module dualDecodeStage_chk (
  input wire logic               clk,
  input wire logic               arstN,
  input wire logic               stall,
  input wire logic               flush,
  input wire logic               validE,
  input wire logic               illegalE,
  input wire logic               armE,
  input wire logic               regWriteE,
  input wire logic               memWriteE,
  input wire logic               branchE,
  input wire logic               jumpE,
  input wire logic               pcSrcE,
  input wire ctrlPkg::flagWriteT flagWriteE
);

  logic anyEnable;
  int   failures = 0;

  assign anyEnable = regWriteE | memWriteE | branchE | jumpE | pcSrcE | (|flagWriteE);

  // a bubble in execute must not write anything
  enablesLowWhenInvalid: assert property (@(posedge clk) disable iff (!arstN)
    !validE |-> !anyEnable)
    else begin
      failures++;
      $error("control enable high while validE is low");
    end

  flushKillsValid: assert property (@(posedge clk) disable iff (!arstN)
    flush |=> !validE)
    else begin
      failures++;
      $error("validE high on the edge after a flush");
    end

  stallHoldsOutputs: assert property (@(posedge clk) disable iff (!arstN)
    (stall && !flush) |=> $stable({validE, illegalE, armE, regWriteE, memWriteE,
                                   branchE, jumpE, pcSrcE, flagWriteE}))
    else begin
      failures++;
      $error("execute outputs changed during a stall");
    end

endmodule

bind dualDecodeStage dualDecodeStage_chk uChk (.*);

`default_nettype wire

/* bench/dualDecodeStage_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "decode_defs.svh"

module dualDecodeStage_tb;
  import isaPkg::*;
  import ctrlPkg::*;

  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 150;

  logic      clk;
  logic      arstN;
  instrT     instr;
  logic      instrValid;
  logic      stall;
  logic      flush;
  logic      validE, illegalE, armE, regWriteE, memWriteE, memSignedE;
  logic      branchE, aluSrcE, pcSrcE, pcResE, jumpE;
  memSizeT   memSizeE;
  aluCtrlT   aluControlE;
  immSrcT    immSrcE;
  resultSrcT resultSrcE;
  condT      condE;
  flagWriteT flagWriteE;
  regSrcT    regSrcE;

  // expected values from the reference model
  logic      eValid, eIllegal, eArm, eRegWrite, eMemWrite, eMemSigned;
  logic      eBranch, eAluSrc, ePcSrc, ePcRes, eJump;
  memSizeT   eMemSize;
  aluCtrlT   eAlu;
  immSrcT    eImm;
  resultSrcT eRes;
  condT      eCond;
  flagWriteT eFlags;
  regSrcT    eRegSrc;
  isaModeT   modelMode;

  int          errors;
  int          testsRun;
  int          testsFailed;
  int          errAtStart;

  dualDecodeStage DUT (.*);

  always #5 clk = ~clk;

  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * 10);
    $display("timeout: tests did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkAlu(input string name, input aluCtrlT got, input aluCtrlT exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkImm(input string name, input immSrcT got, input immSrcT exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkSize(input string name, input memSizeT got, input memSizeT exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkResult(input string name, input resultSrcT got, input resultSrcT exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkRegSrc(input string name, input regSrcT got, input regSrcT exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkFlags(input string name, input flagWriteT got, input flagWriteT exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkCond(input string name, input condT got, input condT exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic logic rvAccepts(input instrT w);
    logic [2:0] f3;
    f3 = w[14:12];
    case (w[6:0])
      rvOpLoad:           return f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
      rvOpStore:          return f3 inside {3'd0, 3'd1, 3'd2};
      rvOpReg, rvOpImm:   return f3 != 3'd3; // sltu not supported
      rvOpBranch, rvOpJal, rvOpJalr, rvOpLui, rvOpAuipc: return 1'b1;
      default:            return 1'b0;
    endcase
  endfunction

  function automatic logic armAccepts(input instrT w);
    if (w[27:26] == 2'b11) return 1'b0;
    if (w[27:26] == 2'b00) return w[24:21] inside {4'd4, 4'd2, 4'd0, 4'd12};
    return 1'b1;
  endfunction

  function automatic aluCtrlT rvAluFor(input logic [2:0] f3, input logic b30, input logic isReg);
    case (f3)
      3'd0:    return (isReg && b30) ? aluSub : aluAdd;
      3'd1:    return aluSll;
      3'd2:    return aluSlt;
      3'd4:    return aluXor;
      3'd5:    return b30 ? aluSra : aluSrl;
      3'd6:    return aluOr;
      default: return aluAnd;
    endcase
  endfunction

  task automatic refRv(input instrT w);
    logic [2:0] f3;
    f3 = w[14:12];
    {eRegWrite, eMemWrite, eMemSigned, eBranch, eAluSrc, ePcRes, eJump} = '0;
    eMemSize = sizeWord;
    eAlu     = aluAdd;
    eImm     = 3'b000;
    eRes     = 2'b00;
    eCond    = 4'b1110; // RISC-V runs unconditionally
    case (w[6:0])
      rvOpLoad: begin
        {eRegWrite, eAluSrc, eRes} = {1'b1, 1'b1, 2'b01};
        eMemSigned = (f3 == 3'd0) || (f3 == 3'd1);
        eMemSize   = (f3[1:0] == 2'd0) ? sizeByte : (f3[1:0] == 2'd1) ? sizeHalf : sizeWord;
      end
      rvOpStore: begin
        {eMemWrite, eAluSrc, eImm} = {1'b1, 1'b1, 3'b001};
        eMemSize = (f3 == 3'd0) ? sizeByte : (f3 == 3'd1) ? sizeHalf : sizeWord;
      end
      rvOpReg: begin
        eRegWrite = 1'b1;
        eAlu      = rvAluFor(f3, w[30], 1'b1);
      end
      rvOpImm: begin
        {eRegWrite, eAluSrc} = 2'b11;
        eAlu = rvAluFor(f3, w[30], 1'b0);
      end
      rvOpBranch: {eBranch, eImm, eAlu} = {1'b1, 3'b010, aluSub};
      rvOpJal:    {eRegWrite, eImm, eRes, eJump} = {1'b1, 3'b011, 2'b10, 1'b1};
      rvOpJalr:   {eRegWrite, eAluSrc, eRes, eJump} = {1'b1, 1'b1, 2'b10, 1'b1};
      rvOpLui:    {eRegWrite, eAluSrc, eImm, eAlu} = {1'b1, 1'b1, 3'b111, aluLui};
      rvOpAuipc:  {eRegWrite, eAluSrc, eImm, eRes, ePcRes} = {2'b11, 3'b111, 2'b10, 1'b1};
      default: ;
    endcase
    ePcSrc = 1'b0;
    eFlags = 2'b00;
  endtask

  task automatic refArm(input instrT w);
    logic [3:0] cmd;
    logic       lBit;
    cmd  = w[24:21];
    lBit = w[20];
    {eRegWrite, eMemWrite, eBranch, eAluSrc} = '0;
    {eMemSigned, ePcRes, eJump} = '0;
    eMemSize = sizeWord;
    eAlu     = aluCtrlT'(0);
    eImm     = 3'b000;
    eRes     = 2'b00;
    eFlags   = 2'b00;
    eRegSrc  = 2'b00;
    eCond    = w[31:28];
    case (w[27:26])
      2'b00: begin
        eAluSrc   = w[25];
        eRegWrite = 1'b1;
        eAlu      = (cmd == 4'd4) ? 4'd0 : (cmd == 4'd2) ? 4'd1 : (cmd == 4'd0) ? 4'd2 : 4'd3;
        eFlags    = {w[20], w[20] & ((cmd == 4'd4) || (cmd == 4'd2))};
      end
      2'b01: begin
        {eImm, eAluSrc} = {3'b001, 1'b1};
        {eRegWrite, eRes, eMemWrite} = {lBit, 1'b0, lBit, ~lBit};
        eRegSrc = {~lBit, 1'b0}; // store data comes from Rd
      end
      default: {eImm, eAluSrc, eBranch, eRegSrc} = {3'b010, 1'b1, 1'b1, 2'b01};
    endcase
    ePcSrc = (w[15:12] == 4'hF) && eRegWrite;
  endtask

  task automatic refDecode(input instrT w);
    logic rvOk;
    logic armOk;
    rvOk  = rvAccepts(w);
    armOk = armAccepts(w);
    if (rvOk && !armOk) modelMode = modeRv;
    if (armOk && !rvOk) modelMode = modeArm;
    eValid   = 1'b1;
    eIllegal = !rvOk && !armOk;
    eArm     = (modelMode == modeArm);
    if (eArm) refArm(w);
    else refRv(w);
    if (eIllegal) {eRegWrite, eMemWrite, eBranch, eJump, ePcSrc, eFlags} = '0;
  endtask

  task automatic checkOutputs();
    checkBit("validE", validE, eValid);
    checkBit("illegalE", illegalE, eIllegal);
    checkBit("armE", armE, eArm);
    checkBit("regWriteE", regWriteE, eRegWrite);
    checkBit("memWriteE", memWriteE, eMemWrite);
    checkBit("branchE", branchE, eBranch);
    checkBit("jumpE", jumpE, eJump);
    checkBit("pcSrcE", pcSrcE, ePcSrc);
    checkFlags("flagWriteE", flagWriteE, eFlags);
    if (!eIllegal) begin
      checkSize("memSizeE", memSizeE, eMemSize);
      checkBit("memSignedE", memSignedE, eMemSigned);
      checkAlu("aluControlE", aluControlE, eAlu);
      checkBit("aluSrcE", aluSrcE, eAluSrc);
      checkImm("immSrcE", immSrcE, eImm);
      checkResult("resultSrcE", resultSrcE, eRes);
      checkCond("condE", condE, eCond);
      if (eArm) checkRegSrc("regSrcE", regSrcE, eRegSrc);
      else checkBit("pcResE", pcResE, ePcRes);
    end
  endtask

  // one word through both registers, then compare
  task automatic runWord(input instrT w);
    refDecode(w);
    @(posedge clk);
    instr      <= w;
    instrValid <= 1'b1;
    @(posedge clk);
    instrValid <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    checkOutputs();
  endtask

  function automatic logic [4:0] rnd5();
    return 5'($urandom);
  endfunction

  function automatic instrT rvR(input logic [6:0] f7, input logic [2:0] f3);
    return {f7, rnd5(), rnd5(), f3, rnd5(), rvOpReg};
  endfunction

  function automatic instrT rvI(input logic [11:0] imm, input logic [2:0] f3, input rvOpT op);
    return {imm, rnd5(), f3, rnd5(), op};
  endfunction

  function automatic instrT rvS(input logic [6:0] op, input logic [2:0] f3);
    return {7'($urandom), rnd5(), rnd5(), f3, rnd5(), op};
  endfunction

  // low 7 bits zero keeps these words off every RISC-V opcode
  function automatic instrT armDp(input condT c, input logic i, input logic [3:0] cmd,
                                  input logic s, input logic [3:0] rd);
    return {c, 2'b00, i, cmd, s, 4'($urandom), rd, rnd5(), 7'b0};
  endfunction

  function automatic instrT armMem(input logic l, input logic [3:0] rd);
    return {4'hE, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, l, 4'($urandom), rd, rnd5(), 7'b0};
  endfunction

  function automatic instrT armB(input condT c);
    return {c, 2'b10, 2'b10, 17'($urandom), 7'b0};
  endfunction

  task automatic startTest();
    errAtStart = errors;
    testsRun++;
  endtask

  task automatic endTest(input string name);
    if (errors == errAtStart) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errAtStart);
      testsFailed++;
    end
  endtask

  task automatic resetTest();
    startTest();
    @(negedge clk);
    checkBit("validE", validE, 1'b0);
    checkBit("illegalE", illegalE, 1'b0);
    checkBit("armE", armE, 1'b0);
    checkBit("regWriteE", regWriteE, 1'b0);
    checkBit("memWriteE", memWriteE, 1'b0);
    checkBit("branchE", branchE, 1'b0);
    checkBit("jumpE", jumpE, 1'b0);
    checkBit("pcSrcE", pcSrcE, 1'b0);
    checkFlags("flagWriteE", flagWriteE, 2'b00);
    endTest("reset");
  endtask

  task automatic rvCoverageTest();
    startTest();
    for (int k = 0; k < 6; k++) begin
      if (k != 3) runWord(rvI(12'($urandom), 3'(k), rvOpLoad)); // every load size
    end
    for (int k = 0; k < 3; k++) runWord(rvS(rvOpStore, 3'(k)));
    runWord(rvR(7'b0000000, 3'd0)); // add
    runWord(rvR(7'b0100000, 3'd0)); // sub
    runWord(rvR(7'b0000000, 3'd1));
    runWord(rvR(7'b0000000, 3'd2));
    runWord(rvR(7'b0000000, 3'd4));
    runWord(rvR(7'b0000000, 3'd5)); // srl
    runWord(rvR(7'b0100000, 3'd5)); // sra
    runWord(rvR(7'b0000000, 3'd6));
    runWord(rvR(7'b0000000, 3'd7));
    runWord(rvI(12'($urandom), 3'd0, rvOpImm));
    runWord(rvI({7'b0100000, rnd5()}, 3'd5, rvOpImm)); // srai
    runWord(rvS(rvOpBranch, 3'd0));
    runWord({20'($urandom), rnd5(), rvOpJal});
    runWord(rvI(12'($urandom), 3'd0, rvOpJalr));
    runWord({20'($urandom), rnd5(), rvOpLui});
    runWord({20'($urandom), rnd5(), rvOpAuipc});
    endTest("riscv coverage");
  endtask

  task automatic armCoverageTest();
    startTest();
    for (int s = 0; s < 2; s++) begin
      runWord(armDp(4'hE, 1'b1, 4'd4, 1'(s), 4'($urandom_range(14, 0))));
      runWord(armDp(4'hE, 1'b0, 4'd2, 1'(s), 4'($urandom_range(14, 0))));
      runWord(armDp(4'h0, 1'b1, 4'd0, 1'(s), 4'($urandom_range(14, 0))));
      runWord(armDp(4'hE, 1'b0, 4'd12, 1'(s), 4'($urandom_range(14, 0))));
    end
    runWord(armMem(1'b1, 4'd3));  // LDR
    runWord(armMem(1'b0, 4'd5));  // STR
    runWord(armB(4'h1));
    runWord(armDp(4'hE, 1'b1, 4'd4, 1'b0, 4'hF)); // write to PC
    endTest("arm coverage");
  endtask

  task automatic modeSwitchTest();
    instrT rvOnly;
    instrT both;
    instrT neither;
    startTest();
    rvOnly  = rvI({4'($urandom), 2'b11, 6'($urandom)}, 3'd0, rvOpImm);
    both    = {12'h008, rnd5(), 3'd0, rnd5(), rvOpImm}; // addi that is also ARM ADD
    neither = {4'hE, 2'b11, 26'h0};
    runWord(rvOnly);
    checkBit("armE", armE, 1'b0);
    runWord(armDp(4'hE, 1'b1, 4'd4, 1'b0, 4'd1));
    checkBit("armE", armE, 1'b1);
    runWord(both);
    checkBit("armE", armE, 1'b1);
    runWord(rvOnly);
    checkBit("armE", armE, 1'b0);
    runWord(both);
    checkBit("armE", armE, 1'b0);
    runWord(neither);
    checkBit("illegalE", illegalE, 1'b1);
    checkBit("armE", armE, 1'b0);
    endTest("mode switching");
  endtask

  task automatic flushShadowTest();
    instrT armWord;
    startTest();
    runWord(rvI(12'h0c0, 3'd0, rvOpImm)); // RISC-V only, mode RISC-V
    armWord = armDp(4'hE, 1'b1, 4'd2, 1'b1, 4'd2);
    @(posedge clk);
    instr      <= armWord;
    instrValid <= 1'b1;
    @(posedge clk);
    flush <= 1'b1; // word in decode is wrong-path
    for (int k = 0; k <= `SHADOW_CYCLES; k++) begin
      @(posedge clk);
      flush <= 1'b0;
      @(negedge clk);
      checkBit("validE", validE, 1'b0);
      checkBit("armE", armE, 1'b0);
      checkBit("regWriteE", regWriteE, 1'b0);
    end
    refDecode(armWord); // first word past the shadow
    @(posedge clk);
    instrValid <= 1'b0;
    @(negedge clk);
    checkOutputs();
    @(posedge clk);
    endTest("flush and shadow");
  endtask

  task automatic stallTest();
    instrT first;
    instrT second;
    startTest();
    first  = rvS(rvOpStore, 3'd2);
    second = armMem(1'b1, 4'hF); // LDR into PC
    refDecode(first);
    @(posedge clk);
    instr      <= first;
    instrValid <= 1'b1;
    @(posedge clk);
    instr      <= second;
    @(posedge clk);
    stall <= 1'b1;
    @(negedge clk);
    checkOutputs();
    repeat (3) begin
      @(posedge clk);
      @(negedge clk);
      checkOutputs(); // held
    end
    refDecode(second);
    @(posedge clk);
    stall      <= 1'b0;
    instrValid <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    checkOutputs();
    @(posedge clk);
    endTest("stall");
  endtask

  initial begin
    void'($urandom(32'hb42b));
    clk         = 1'b0;
    arstN       = 1'b0;
    instr       = '0;
    instrValid  = 1'b0;
    stall       = 1'b0;
    flush       = 1'b0;
    errors      = 0;
    testsRun    = 0;
    testsFailed = 0;
    modelMode   = modeRv;
    repeat (5) @(posedge clk);
    arstN <= 1'b1;
    resetTest();
    rvCoverageTest();
    armCoverageTest();
    modeSwitchTest();
    flushShadowTest();
    stallTest();
    errors += DUT.uChk.failures;
    $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+rtl
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/decodeIf.sv
rtl/rvDecoder.sv
rtl/armDecoder.sv
rtl/isaModeFsm.sv
rtl/flushShadowTimer.sv
rtl/ctrlSelectReg.sv
rtl/dualDecodeStage.sv
bench/dualDecodeStage_chk.sv
bench/dualDecodeStage_tb.sv

/* rtl/armDecoder.sv */
`timescale 1ns/100ps
`default_nettype none

module armDecoder (
  input  isaPkg::instrT instr,
  decodeIf.src          ctrl
);
  import isaPkg::*;
  import ctrlPkg::*;

  armOpT      op;
  logic [5:0] funct;
  logic [3:0] rd;
  logic       aluOp;     // data-processing word
  logic       memToReg;
  logic [1:0] immSel;
  logic [1:0] aluSel;
  logic       mainOk;
  logic       aluOk;

  assign op    = instr[27:26];
  assign funct = instr[25:20];
  assign rd    = instr[15:12];

  // main decoder
  always_comb begin
    mainOk        = 1'b1;
    aluOp         = 1'b0;
    memToReg      = 1'b0;
    immSel        = 2'b00;
    ctrl.regSrc   = 2'b00;
    ctrl.aluSrc   = 1'b0;
    ctrl.regWrite = 1'b0;
    ctrl.memWrite = 1'b0;
    ctrl.branch   = 1'b0;
    case (op)
      armOpDp: begin
        ctrl.aluSrc   = funct[5]; // I bit
        ctrl.regWrite = 1'b1;
        aluOp         = 1'b1;
      end
      armOpMem: begin
        immSel        = 2'b01;    // 12-bit offset
        ctrl.aluSrc   = 1'b1;
        memToReg      = funct[0];
        ctrl.regWrite = funct[0]; // LDR
        ctrl.memWrite = ~funct[0]; // STR
        ctrl.regSrc   = {~funct[0], 1'b0}; // STR reads Rd as data
      end
      armOpBr: begin
        immSel      = 2'b10;      // 24-bit word offset
        ctrl.aluSrc = 1'b1;
        ctrl.branch = 1'b1;
        ctrl.regSrc = 2'b01;      // PC as Rn
      end
      default: mainOk = 1'b0;
    endcase
  end

  // DP ALU decoder
  always_comb begin
    aluOk          = 1'b1;
    aluSel         = 2'b00;       // add for address and branch target
    ctrl.flagWrite = 2'b00;
    if (aluOp) begin
      case (funct[4:1])
        4'b0100: aluSel = 2'b00;  // ADD
        4'b0010: aluSel = 2'b01;  // SUB
        4'b0000: aluSel = 2'b10;  // AND
        4'b1100: aluSel = 2'b11;  // ORR
        default: aluOk = 1'b0;
      endcase
      ctrl.flagWrite[1] = funct[0];              // S bit sets NZ
      ctrl.flagWrite[0] = funct[0] & ~aluSel[1]; // CV for arithmetic only
    end
  end

  assign ctrl.accept     = mainOk & aluOk;
  assign ctrl.aluControl = aluCtrlT'(aluSel);
  assign ctrl.immSrc     = immSrcT'(immSel);
  assign ctrl.resultSrc  = resultSrcT'(memToReg);
  assign ctrl.memSize    = sizeWord;
  assign ctrl.memSigned  = 1'b0;
  assign ctrl.cond       = instr[31:28];
  assign ctrl.pcSrc      = (rd == 4'hF) & ctrl.regWrite; // write to R15
  assign ctrl.pcRes      = 1'b0;
  assign ctrl.jump       = 1'b0;

endmodule

`default_nettype wire

/* rtl/ctrlPkg.sv */
`default_nettype none

`include "decode_defs.svh"

package ctrlPkg;

  typedef logic [`ALU_W-1:0] aluCtrlT;
  typedef logic [2:0]        immSrcT;
  typedef logic [1:0]        memSizeT;
  typedef logic [1:0]        resultSrcT;
  typedef logic [1:0]        flagWriteT; // {NZ, CV}
  typedef logic [1:0]        regSrcT;
  typedef logic [$clog2(`SHADOW_CYCLES+1)-1:0] shadowCntT;

  typedef enum logic {modeRv, modeArm} isaModeT;

  localparam memSizeT sizeByte = 2'b00;
  localparam memSizeT sizeHalf = 2'b01;
  localparam memSizeT sizeWord = 2'b10;

  // ALU operations as seen by the execute stage
  localparam aluCtrlT aluAdd = 4'b0000;
  localparam aluCtrlT aluSub = 4'b0001;
  localparam aluCtrlT aluAnd = 4'b0010;
  localparam aluCtrlT aluOr  = 4'b0011;
  localparam aluCtrlT aluXor = 4'b0100;
  localparam aluCtrlT aluSlt = 4'b0101;
  localparam aluCtrlT aluLui = 4'b0110; // pass immediate
  localparam aluCtrlT aluSll = 4'b1000;
  localparam aluCtrlT aluSrl = 4'b1001;
  localparam aluCtrlT aluSra = 4'b1010;

endpackage

`default_nettype wire

/* rtl/ctrlSelectReg.sv */
`timescale 1ns/100ps
`default_nettype none

module ctrlSelectReg (
  input  logic               clk,
  input  logic               arstN,
  input  logic               stall,
  input  logic               flush,
  input  logic               wordValid,
  input  logic               shadow,
  input  logic               illegal,
  input  ctrlPkg::isaModeT   mode,
  decodeIf.dst               rvCtrl,
  decodeIf.dst               armCtrl,
  output logic               validE,
  output logic               illegalE,
  output logic               armE,
  output logic               regWriteE,
  output logic               memWriteE,
  output ctrlPkg::memSizeT   memSizeE,
  output logic               memSignedE,
  output ctrlPkg::aluCtrlT   aluControlE,
  output logic               branchE,
  output logic               aluSrcE,
  output ctrlPkg::immSrcT    immSrcE,
  output ctrlPkg::resultSrcT resultSrcE,
  output isaPkg::condT       condE,
  output logic               pcSrcE,
  output ctrlPkg::flagWriteT flagWriteE,
  output ctrlPkg::regSrcT    regSrcE,
  output logic               pcResE,
  output logic               jumpE
);
  import ctrlPkg::*;

  logic isArm;
  logic live;   // word takes effect
  logic keep;   // live and legal
  logic armKeep;

  assign isArm   = (mode == modeArm);
  assign live    = wordValid & ~shadow;
  assign keep    = live & ~illegal;
  assign armKeep = keep & isArm;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validE     <= 1'b0;
      illegalE   <= 1'b0;
      armE       <= 1'b0;
      regWriteE  <= 1'b0;
      memWriteE  <= 1'b0;
      branchE    <= 1'b0;
      jumpE      <= 1'b0;
      pcSrcE     <= 1'b0;
      flagWriteE <= '0;
    end else if (flush) begin
      validE     <= 1'b0;
      illegalE   <= 1'b0;
      regWriteE  <= 1'b0;
      memWriteE  <= 1'b0;
      branchE    <= 1'b0;
      jumpE      <= 1'b0;
      pcSrcE     <= 1'b0;
      flagWriteE <= '0;
    end else if (!stall) begin
      validE     <= live;
      illegalE   <= illegal;
      armE       <= isArm;
      regWriteE  <= keep & (isArm ? armCtrl.regWrite : rvCtrl.regWrite);
      memWriteE  <= keep & (isArm ? armCtrl.memWrite : rvCtrl.memWrite);
      branchE    <= keep & (isArm ? armCtrl.branch : rvCtrl.branch);
      jumpE      <= keep & ~isArm & rvCtrl.jump;
      pcSrcE     <= armKeep & armCtrl.pcSrc;
      flagWriteE <= armKeep ? armCtrl.flagWrite : '0;
    end
  end

  // data fields, meaningful only alongside validE
  always_ff @(posedge clk) begin
    if (!stall) begin
      memSizeE    <= isArm ? armCtrl.memSize : rvCtrl.memSize;
      memSignedE  <= isArm ? armCtrl.memSigned : rvCtrl.memSigned;
      aluControlE <= isArm ? armCtrl.aluControl : rvCtrl.aluControl;
      aluSrcE     <= isArm ? armCtrl.aluSrc : rvCtrl.aluSrc;
      immSrcE     <= isArm ? armCtrl.immSrc : rvCtrl.immSrc;
      resultSrcE  <= isArm ? armCtrl.resultSrc : rvCtrl.resultSrc;
      condE       <= isArm ? armCtrl.cond : rvCtrl.cond;
      regSrcE     <= armCtrl.regSrc;
      pcResE      <= rvCtrl.pcRes;
    end
  end

endmodule

`default_nettype wire

/* rtl/decodeIf.sv */
`timescale 1ns/100ps
`default_nettype none

interface decodeIf;
  import isaPkg::*;
  import ctrlPkg::*;

  logic      accept;     // word is a supported instruction
  logic      regWrite;
  logic      memWrite;
  memSizeT   memSize;
  logic      memSigned;
  aluCtrlT   aluControl;
  logic      branch;
  logic      aluSrc;
  immSrcT    immSrc;
  resultSrcT resultSrc;
  condT      cond;
  logic      pcSrc;      // ARM
  flagWriteT flagWrite;  // ARM
  regSrcT    regSrc;     // ARM
  logic      pcRes;      // RISC-V
  logic      jump;       // RISC-V

  modport src (
    output accept, regWrite, memWrite, memSize, memSigned, aluControl, branch,
           aluSrc, immSrc, resultSrc, cond, pcSrc, flagWrite, regSrc, pcRes, jump
  );

  modport dst (
    input accept, regWrite, memWrite, memSize, memSigned, aluControl, branch,
          aluSrc, immSrc, resultSrc, cond, pcSrc, flagWrite, regSrc, pcRes, jump
  );

endinterface

`default_nettype wire

/* rtl/decode_defs.svh */
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// fetched word, same size for both ISAs
`define INSTR_W 32

// edges after a flush during which fetched words are wrong-path
`define SHADOW_CYCLES 2

// ALU code width, ARM uses only the low 2 bits
`define ALU_W 4

`endif

/* rtl/dualDecodeStage.sv */
`timescale 1ns/100ps
`default_nettype none

module dualDecodeStage (
  input  logic               clk,
  input  logic               arstN,
  input  isaPkg::instrT      instr,
  input  logic               instrValid,
  input  logic               stall,
  input  logic               flush,
  output logic               validE,
  output logic               illegalE,
  output logic               armE,
  output logic               regWriteE,
  output logic               memWriteE,
  output ctrlPkg::memSizeT   memSizeE,
  output logic               memSignedE,
  output ctrlPkg::aluCtrlT   aluControlE,
  output logic               branchE,
  output logic               aluSrcE,
  output ctrlPkg::immSrcT    immSrcE,
  output ctrlPkg::resultSrcT resultSrcE,
  output isaPkg::condT       condE,
  output logic               pcSrcE,
  output ctrlPkg::flagWriteT flagWriteE,
  output ctrlPkg::regSrcT    regSrcE,
  output logic               pcResE,
  output logic               jumpE
);
  import isaPkg::*;
  import ctrlPkg::*;

  instrT   instrD;     // fetch-to-decode register
  logic    validD;
  logic    wordValid;
  logic    shadow;
  logic    illegal;
  isaModeT mode;

  decodeIf rvCtrl ();
  decodeIf armCtrl ();

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validD <= 1'b0;
    end else if (flush) begin
      validD <= 1'b0;
    end else if (!stall) begin
      validD <= instrValid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      instrD <= instr;
    end
  end

  // a word being flushed must not steer the mode
  assign wordValid = validD & ~flush;

  rvDecoder uRvDec (
    .instr (instrD),
    .ctrl  (rvCtrl)
  );

  armDecoder uArmDec (
    .instr (instrD),
    .ctrl  (armCtrl)
  );

  isaModeFsm uModeFsm (.*);

  flushShadowTimer uShadow (.*);

  ctrlSelectReg uCtrlReg (.*);

endmodule

`default_nettype wire

/* rtl/flushShadowTimer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "decode_defs.svh"

module flushShadowTimer (
  input  logic clk,
  input  logic arstN,
  input  logic flush,
  output logic shadow
);
  import ctrlPkg::*;

  shadowCntT count;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      count <= '0;
    end else if (flush) begin
      count <= shadowCntT'(`SHADOW_CYCLES); // restart on every flush
    end else if (count != '0) begin
      count <= count - 1'b1;                // runs through stalls
    end
  end

  assign shadow = (count != '0);

endmodule

`default_nettype wire

/* rtl/isaModeFsm.sv */
`timescale 1ns/100ps
`default_nettype none

module isaModeFsm (
  input  logic             clk,
  input  logic             arstN,
  input  logic             wordValid,
  input  logic             shadow,
  decodeIf.dst             rvCtrl,
  decodeIf.dst             armCtrl,
  output ctrlPkg::isaModeT mode,
  output logic             illegal
);
  import ctrlPkg::*;

  isaModeT modeQ;
  isaModeT modeNext;
  logic    decide;    // word may steer the mode

  assign decide = wordValid & ~shadow;

  always_comb begin
    case ({rvCtrl.accept, armCtrl.accept})
      2'b10:   modeNext = modeRv;
      2'b01:   modeNext = modeArm;
      default: modeNext = modeQ;  // both or neither
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      modeQ <= modeRv;
    end else if (decide) begin
      modeQ <= modeNext;
    end
  end

  assign mode    = decide ? modeNext : modeQ;
  assign illegal = decide & ~rvCtrl.accept & ~armCtrl.accept;

endmodule

`default_nettype wire

/* rtl/isaPkg.sv */
`default_nettype none

`include "decode_defs.svh"

package isaPkg;

  typedef logic [`INSTR_W-1:0] instrT;
  typedef logic [3:0]          condT;
  typedef logic [6:0]          rvOpT;
  typedef logic [1:0]          armOpT;

  localparam condT condAlways = 4'b1110; // ARM AL code

  // RV32I major opcodes
  localparam rvOpT rvOpLoad   = 7'b0000011;
  localparam rvOpT rvOpStore  = 7'b0100011;
  localparam rvOpT rvOpReg    = 7'b0110011;
  localparam rvOpT rvOpBranch = 7'b1100011;
  localparam rvOpT rvOpImm    = 7'b0010011;
  localparam rvOpT rvOpJal    = 7'b1101111;
  localparam rvOpT rvOpJalr   = 7'b1100111;
  localparam rvOpT rvOpLui    = 7'b0110111;
  localparam rvOpT rvOpAuipc  = 7'b0010111;

  // ARM op field, bits 27:26
  localparam armOpT armOpDp  = 2'b00;
  localparam armOpT armOpMem = 2'b01;
  localparam armOpT armOpBr  = 2'b10;

endpackage

`default_nettype wire

/* rtl/rvDecoder.sv */
`timescale 1ns/100ps
`default_nettype none

module rvDecoder (
  input  isaPkg::instrT instr,
  decodeIf.src          ctrl
);
  import isaPkg::*;
  import ctrlPkg::*;

  rvOpT       opcode;
  logic [2:0] funct3;
  logic       funct7b5;
  logic       rTypeSub;
  logic [1:0] aluOp;
  logic       mainOk;
  logic       aluOk;

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7b5 = instr[30];
  assign rTypeSub = funct7b5 & instr[5]; // addi has no sub form

  // main decoder
  always_comb begin
    mainOk         = 1'b1;
    aluOp          = 2'b00;
    ctrl.regWrite  = 1'b0;
    ctrl.memWrite  = 1'b0;
    ctrl.memSize   = sizeWord;
    ctrl.memSigned = 1'b0;
    ctrl.branch    = 1'b0;
    ctrl.aluSrc    = 1'b0;
    ctrl.immSrc    = 3'b000;  // I-type
    ctrl.resultSrc = 2'b00;   // ALU result
    ctrl.jump      = 1'b0;
    ctrl.pcRes     = 1'b0;
    case (opcode)
      rvOpLoad: begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrc    = 1'b1;
        ctrl.resultSrc = 2'b01;  // memory data
        case (funct3)
          3'b000:  {ctrl.memSigned, ctrl.memSize} = {1'b1, sizeByte}; // lb
          3'b001:  {ctrl.memSigned, ctrl.memSize} = {1'b1, sizeHalf}; // lh
          3'b010:  {ctrl.memSigned, ctrl.memSize} = {1'b0, sizeWord}; // lw
          3'b100:  {ctrl.memSigned, ctrl.memSize} = {1'b0, sizeByte}; // lbu
          3'b101:  {ctrl.memSigned, ctrl.memSize} = {1'b0, sizeHalf}; // lhu
          default: mainOk = 1'b0;
        endcase
      end
      rvOpStore: begin
        ctrl.memWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.immSrc   = 3'b001;  // S-type
        case (funct3)
          3'b000:  ctrl.memSize = sizeByte;
          3'b001:  ctrl.memSize = sizeHalf;
          3'b010:  ctrl.memSize = sizeWord;
          default: mainOk = 1'b0;
        endcase
      end
      rvOpReg: begin
        ctrl.regWrite = 1'b1;
        aluOp         = 2'b10;
      end
      rvOpBranch: begin
        ctrl.branch = 1'b1;
        ctrl.immSrc = 3'b010;    // B-type
        aluOp       = 2'b01;     // compare by subtract
      end
      rvOpImm: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        aluOp         = 2'b10;
      end
      rvOpJal: begin
        ctrl.regWrite  = 1'b1;
        ctrl.immSrc    = 3'b011; // J-type
        ctrl.resultSrc = 2'b10;  // link address
        ctrl.jump      = 1'b1;
      end
      rvOpJalr: begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrc    = 1'b1;
        ctrl.resultSrc = 2'b10;
        ctrl.jump      = 1'b1;   // target from ALU
      end
      rvOpLui: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.immSrc   = 3'b111;  // U-type
        aluOp         = 2'b11;
      end
      rvOpAuipc: begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrc    = 1'b1;
        ctrl.immSrc    = 3'b111;
        ctrl.resultSrc = 2'b10;
        ctrl.pcRes     = 1'b1;   // pc plus upper immediate
      end
      default: mainOk = 1'b0;
    endcase
  end

  // ALU decoder
  always_comb begin
    aluOk = 1'b1;
    case (aluOp)
      2'b00: ctrl.aluControl = aluAdd;
      2'b01: ctrl.aluControl = aluSub;
      2'b11: ctrl.aluControl = aluLui;
      default: begin
        case (funct3)
          3'b000: ctrl.aluControl = rTypeSub ? aluSub : aluAdd;
          3'b001: ctrl.aluControl = aluSll;
          3'b010: ctrl.aluControl = aluSlt;
          3'b100: ctrl.aluControl = aluXor;
          3'b101: ctrl.aluControl = funct7b5 ? aluSra : aluSrl;
          3'b110: ctrl.aluControl = aluOr;
          3'b111: ctrl.aluControl = aluAnd;
          default: begin
            ctrl.aluControl = aluAdd;
            aluOk           = 1'b0; // no unsigned compare in the ALU
          end
        endcase
      end
    endcase
  end

  assign ctrl.accept    = mainOk & aluOk;
  assign ctrl.cond      = condAlways;
  assign ctrl.pcSrc     = 1'b0;  // ARM fields unused here
  assign ctrl.flagWrite = '0;
  assign ctrl.regSrc    = '0;

endmodule

`default_nettype wire
